/* tl_cases.txt */
# name op type addr data rd | cmd exp_addr exp_data exp_index   (hex, - for none)
# op LD load, ST store, NOP one idle cycle, OUT output owed by a blocked operation
# On NOP and OUT lines the type column is the type of the flushed store
idle_empty NOP -    -        -        -  -     -        -        -
cold_word  LD  WORD 00001040 -        03 MISS  00001040 -        5
cold_half  LD  HALF 00002236 -        04 MISS  00002236 -        6
hit_byte   LD  BYTE 0000104d -        07 LOAD  0000104d -        5
hit_word   LD  WORD 00002230 -        08 LOAD  00002230 -        6
st_word    ST  WORD 00003000 a1b2c3d4 -  -     -        -        -
fwd_word   LD  WORD 00003000 -        09 FWD   00003000 a1b2c3d4 -
fwd_byte   LD  BYTE 00003002 -        0a FWD   00003002 000000b2 -
fwd_half   LD  HALF 00003002 -        0b FWD   00003002 0000a1b2 -
st_half    ST  HALF 00003000 00005566 -  -     -        -        -
fwd_newest LD  HALF 00003000 -        0c FWD   00003000 00005566 -
fwd_nbyte  LD  BYTE 00003001 -        0d FWD   00003001 00000055 -
flush_w    NOP WORD -        -        -  FLUSH 00003000 a1b2c3d4 -
flush_h    NOP HALF -        -        -  FLUSH 00003000 00005566 -
st_w2      ST  WORD 00001044 11223344 -  -     -        -        -
st_b       ST  BYTE 00001045 000000ee -  -     -        -        -
drain_w    OUT WORD -        -        -  FLUSH 00001044 11223344 -
drain_b    OUT BYTE -        -        -  FLUSH 00001045 000000ee -
part_hit   LD  WORD 00001044 -        0e LOAD  00001044 -        5
st_h5      ST  HALF 00005002 0000beef -  -     -        -        -
drain_h    OUT HALF -        -        -  FLUSH 00005002 0000beef -
part_miss  LD  WORD 00005000 -        0f MISS  00005000 -        7
st_1       ST  WORD 00006000 00000001 -  -     -        -        -
st_2       ST  BYTE 00006005 00000002 -  -     -        -        -
st_3       ST  HALF 0000600a 00000303 -  -     -        -        -
st_4       ST  WORD 0000600c 00000004 -  -     -        -        -
drain_1    OUT WORD -        -        -  FLUSH 00006000 00000001 -
st_5       ST  WORD 00006010 00000005 -  -     -        -        -
flush_2    NOP BYTE -        -        -  FLUSH 00006005 00000002 -
flush_3    NOP HALF -        -        -  FLUSH 0000600a 00000303 -
flush_4    NOP WORD -        -        -  FLUSH 0000600c 00000004 -
flush_5    NOP WORD -        -        -  FLUSH 00006010 00000005 -
idle_end   NOP -    -        -        -  -     -        -        -

/* project.f */
tl_pkg.sv
dcache_tag_array.sv
store_buffer.sv
tl_control.sv
tl_subsystem.sv
tb_tl_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_tl_subsystem -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation passed" \
    && echo "Run result: PASS" \
    || { echo "Run result: FAIL"; exit 1; }

/* tb_tl_subsystem.sv */
`timescale 1ns/10ps

module tb_tl_subsystem import tl_pkg::*; ();

    logic                         clk_i;
    logic                         reset_i;
    logic                         ex_valid_i;
    logic                         ex_rd_i;
    logic                         ex_wr_i;
    memop_type_e                  ex_type_i;
    logic [ADDR_SIZE-1:0]         ex_addr_i;
    logic [WORD_SIZE-1:0]         ex_data_i;
    logic [REG_SIZE-1:0]          ex_rf_waddr_i;
    logic                         ex_ready_o;
    logic                         mmu_req_valid_o;
    logic [ADDR_SIZE-1:0]         mmu_req_addr_o;
    logic                         mmu_req_ready_i;
    logic                         mmu_fill_valid_i;
    logic [DCACHE_INDEX_SIZE-1:0] mmu_fill_index_i;
    logic                         mem_valid_o;
    mem_cmd_e                     mem_cmd_o;
    logic [ADDR_SIZE-1:0]         mem_addr_o;
    logic [WORD_SIZE-1:0]         mem_data_o;
    memop_type_e                  mem_type_o;
    logic [DCACHE_INDEX_SIZE-1:0] mem_index_o;
    logic [REG_SIZE-1:0]          mem_rf_waddr_o;

    // One entry per line of the case file
    string       case_name[$];
    string       case_op[$];
    memop_type_e case_type[$];
    logic [31:0] case_addr[$];
    logic [31:0] case_data[$];
    logic [31:0] case_rd[$];
    string       case_cmd[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    logic [31:0] exp_index[$];
    int          exp_q[$];        // Cases still owed a memory-stage output, in order

    int cur_case    = 0;
    int mmu_reqs    = 0;
    int cycles      = 0;
    int cycle_limit = 1000;

    tl_subsystem tl_subsystem_i (.*);

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                               name, field, expected, actual));
        end
    endtask

    function automatic logic [31:0] hex_field(input string s);
        logic [31:0] v;
        v = '0;
        if (s != "-") void'($sscanf(s, "%h", v));
        return v;
    endfunction

    function automatic memop_type_e type_code(input string s);
        if (s == "BYTE") return BYTE;
        if (s == "HALF") return HALF;
        return WORD;
    endfunction

    function automatic mem_cmd_e cmd_code(input string s);
        if (s == "FWD") return MEM_FWD;
        if (s == "FLUSH") return MEM_FLUSH;
        if (s == "LOAD" || s == "MISS") return MEM_LOAD; // A miss ends as a plain load
        return MEM_NONE;
    endfunction

    task automatic read_cases();
        int    fd;
        int    n;
        string line;
        string first;
        string f_name, f_op, f_type, f_addr, f_data, f_rd, f_cmd, f_eaddr, f_edata, f_eidx;
        fd = $fopen("tl_cases.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open tl_cases.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s", first);
                if (n == 1 && first.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %s %s %s %s %s %s %s %s %s", f_name, f_op, f_type,
                                f_addr, f_data, f_rd, f_cmd, f_eaddr, f_edata, f_eidx);
                    if (n != 10) begin
                        fail_run({"Malformed line in tl_cases.txt: ", line});
                    end else begin
                        case_name.push_back(f_name);
                        case_op.push_back(f_op);
                        case_type.push_back(type_code(f_type));
                        case_addr.push_back(hex_field(f_addr));
                        case_data.push_back(hex_field(f_data));
                        case_rd.push_back(hex_field(f_rd));
                        case_cmd.push_back(f_cmd);
                        exp_addr.push_back(hex_field(f_eaddr));
                        exp_data.push_back(hex_field(f_edata));
                        exp_index.push_back(hex_field(f_eidx));
                        if (f_cmd != "-") exp_q.push_back(case_name.size() - 1);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Holds the operation until the stage takes it
    task automatic transfer(input int i);
        int reqs_before;
        reqs_before   = mmu_reqs;
        @(negedge clk_i);
        ex_valid_i    = 1'b1;
        ex_rd_i       = (case_op[i] == "LD");
        ex_wr_i       = (case_op[i] == "ST");
        ex_type_i     = case_type[i];
        ex_addr_i     = case_addr[i];
        ex_data_i     = case_data[i];
        ex_rf_waddr_i = REG_SIZE'(case_rd[i]);
        #1;
        while (ex_ready_o !== 1'b1) begin  // Stalled by a miss or a drain
            @(negedge clk_i);
            #1;
        end
        @(posedge clk_i);
        check_value(case_name[i], "mmu requests", (case_cmd[i] == "MISS") ? 32'd1 : 32'd0,
                    32'(mmu_reqs - reqs_before));
    endtask

    task automatic idle_cycle();
        @(negedge clk_i);
        ex_valid_i = 1'b0;
        ex_rd_i    = 1'b0;
        ex_wr_i    = 1'b0;
        @(posedge clk_i);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // MMU answers each fill request, victim lines round robin from line 5
    initial begin : mmu_model
        int victim;
        void'($urandom(32'h1104));
        victim           = 5;
        mmu_req_ready_i  = 1'b0;
        mmu_fill_valid_i = 1'b0;
        mmu_fill_index_i = '0;
        forever begin
            @(negedge clk_i);
            if (!reset_i && mmu_req_valid_o === 1'b1) begin
                mmu_reqs++;
                check_value(case_name[cur_case], "mmu address",
                            case_addr[cur_case] & ~32'hf, mmu_req_addr_o);
                repeat ($urandom % 6) @(negedge clk_i);
                mmu_req_ready_i = 1'b1;
                @(negedge clk_i);
                mmu_req_ready_i = 1'b0;
                repeat ($urandom % 6) @(negedge clk_i);
                mmu_fill_valid_i = 1'b1;
                mmu_fill_index_i = DCACHE_INDEX_SIZE'(victim);
                @(negedge clk_i);
                mmu_fill_valid_i = 1'b0;
                victim = (victim + 1) % DCACHE_LINES;
            end
        end
    end

    always @(negedge clk_i) begin : mem_monitor
        int k;
        if (!reset_i && mem_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run($sformatf("Unexpected memory-stage output %s at address %h",
                                   mem_cmd_o.name(), mem_addr_o));
            end else begin
                k = exp_q.pop_front();
                check_value(case_name[k], "command", 32'(cmd_code(case_cmd[k])), 32'(mem_cmd_o));
                check_value(case_name[k], "address", exp_addr[k], mem_addr_o);
                check_value(case_name[k], "type", 32'(case_type[k]), 32'(mem_type_o));
                if (case_cmd[k] == "LOAD" || case_cmd[k] == "MISS") begin
                    check_value(case_name[k], "index", exp_index[k], 32'(mem_index_o));
                end else begin
                    check_value(case_name[k], "data", exp_data[k], mem_data_o);
                end
                if (case_cmd[k] != "FLUSH") begin
                    check_value(case_name[k], "dest reg", case_rd[k], 32'(mem_rf_waddr_o));
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > cycle_limit) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        reset_i       = 1'b1;
        ex_valid_i    = 1'b0;
        ex_rd_i       = 1'b0;
        ex_wr_i       = 1'b0;
        ex_type_i     = WORD;
        ex_addr_i     = '0;
        ex_data_i     = '0;
        ex_rf_waddr_i = '0;
        read_cases();
        cycle_limit = 40 * case_name.size() + 20;  // Margin for reset and final flush
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        check_value("reset", "ex ready", 32'd0, 32'(ex_ready_o));
        check_value("reset", "mem valid", 32'd0, 32'(mem_valid_o));
        check_value("reset", "mmu request", 32'd0, 32'(mmu_req_valid_o));
        for (int i = 0; i < case_name.size(); i++) begin
            cur_case = i;
            if (case_op[i] == "LD" || case_op[i] == "ST") begin
                transfer(i);
            end else if (case_op[i] == "NOP") begin
                idle_cycle();
            end
        end
        idle_cycle();
        while (exp_q.size() != 0) @(negedge clk_i);
        repeat (4) @(negedge clk_i);  // Catch any stray output
        $display("Simulation passed");
        $finish;
    end

endmodule

/* tl_subsystem.sv */
`timescale 1ns/10ps

module tl_subsystem import tl_pkg::*; (
    input  logic                         clk_i,
    input  logic                         reset_i,
    // Execute
    input  logic                         ex_valid_i,
    input  logic                         ex_rd_i,
    input  logic                         ex_wr_i,
    input  memop_type_e                  ex_type_i,
    input  logic [ADDR_SIZE-1:0]         ex_addr_i,
    input  logic [WORD_SIZE-1:0]         ex_data_i,
    input  logic [REG_SIZE-1:0]          ex_rf_waddr_i,
    output logic                         ex_ready_o,
    // MMU
    output logic                         mmu_req_valid_o,
    output logic [ADDR_SIZE-1:0]         mmu_req_addr_o,
    input  logic                         mmu_req_ready_i,
    input  logic                         mmu_fill_valid_i,
    input  logic [DCACHE_INDEX_SIZE-1:0] mmu_fill_index_i,
    // Memory stage
    output logic                         mem_valid_o,
    output mem_cmd_e                     mem_cmd_o,
    output logic [ADDR_SIZE-1:0]         mem_addr_o,
    output logic [WORD_SIZE-1:0]         mem_data_o,
    output memop_type_e                  mem_type_o,
    output logic [DCACHE_INDEX_SIZE-1:0] mem_index_o,
    output logic [REG_SIZE-1:0]          mem_rf_waddr_o
);

    logic [DCACHE_TAG_SIZE-1:0]   lookup_tag;
    logic                         fill_en;
    logic [DCACHE_TAG_SIZE-1:0]   fill_tag;
    logic                         tag_hit;
    logic [DCACHE_INDEX_SIZE-1:0] tag_index;

    logic                 sb_push;
    logic                 sb_pop;
    logic                 sb_full;
    logic                 sb_nonempty;
    logic                 fwd_hit;
    logic [WORD_SIZE-1:0] fwd_data;
    logic                 conflict;
    logic [ADDR_SIZE-1:0] drain_addr;
    logic [WORD_SIZE-1:0] drain_data;
    memop_type_e          drain_type;

    dcache_tag_array dcache_tag_array_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .lookup_tag_i (lookup_tag),
        .fill_en_i    (fill_en),
        .fill_tag_i   (fill_tag),
        .fill_index_i (mmu_fill_index_i),
        .hit_o        (tag_hit),
        .index_o      (tag_index)
    );

    // Loads and stores both look here using the execute fields
    store_buffer store_buffer_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .push_i       (sb_push),
        .pop_i        (sb_pop),
        .addr_i       (ex_addr_i),
        .data_i       (ex_data_i),
        .type_i       (ex_type_i),
        .full_o       (sb_full),
        .nonempty_o   (sb_nonempty),
        .fwd_hit_o    (fwd_hit),
        .fwd_data_o   (fwd_data),
        .conflict_o   (conflict),
        .drain_addr_o (drain_addr),
        .drain_data_o (drain_data),
        .drain_type_o (drain_type)
    );

    tl_control tl_control_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .ex_valid_i       (ex_valid_i),
        .ex_rd_i          (ex_rd_i),
        .ex_wr_i          (ex_wr_i),
        .ex_type_i        (ex_type_i),
        .ex_addr_i        (ex_addr_i),
        .ex_rf_waddr_i    (ex_rf_waddr_i),
        .ex_ready_o       (ex_ready_o),
        .tag_hit_i        (tag_hit),
        .tag_index_i      (tag_index),
        .sb_full_i        (sb_full),
        .sb_nonempty_i    (sb_nonempty),
        .fwd_hit_i        (fwd_hit),
        .fwd_data_i       (fwd_data),
        .conflict_i       (conflict),
        .drain_addr_i     (drain_addr),
        .drain_data_i     (drain_data),
        .drain_type_i     (drain_type),
        .lookup_tag_o     (lookup_tag),
        .fill_en_o        (fill_en),
        .fill_tag_o       (fill_tag),
        .sb_push_o        (sb_push),
        .sb_pop_o         (sb_pop),
        .mmu_req_valid_o  (mmu_req_valid_o),
        .mmu_req_addr_o   (mmu_req_addr_o),
        .mmu_req_ready_i  (mmu_req_ready_i),
        .mmu_fill_valid_i (mmu_fill_valid_i),
        .mem_valid_o      (mem_valid_o),
        .mem_cmd_o        (mem_cmd_o),
        .mem_addr_o       (mem_addr_o),
        .mem_data_o       (mem_data_o),
        .mem_type_o       (mem_type_o),
        .mem_index_o      (mem_index_o),
        .mem_rf_waddr_o   (mem_rf_waddr_o)
    );

endmodule

/* tl_control.sv */
`timescale 1ns/10ps

module tl_control import tl_pkg::*; (
    input  logic                         clk_i,
    input  logic                         reset_i,
    // Execute side
    input  logic                         ex_valid_i,
    input  logic                         ex_rd_i,
    input  logic                         ex_wr_i,
    input  memop_type_e                  ex_type_i,
    input  logic [ADDR_SIZE-1:0]         ex_addr_i,
    input  logic [REG_SIZE-1:0]          ex_rf_waddr_i,
    output logic                         ex_ready_o,
    // Results from tag array and store buffer
    input  logic                         tag_hit_i,
    input  logic [DCACHE_INDEX_SIZE-1:0] tag_index_i,
    input  logic                         sb_full_i,
    input  logic                         sb_nonempty_i,
    input  logic                         fwd_hit_i,
    input  logic [WORD_SIZE-1:0]         fwd_data_i,
    input  logic                         conflict_i,
    input  logic [ADDR_SIZE-1:0]         drain_addr_i,
    input  logic [WORD_SIZE-1:0]         drain_data_i,
    input  memop_type_e                  drain_type_i,
    // Block controls
    output logic [DCACHE_TAG_SIZE-1:0]   lookup_tag_o,
    output logic                         fill_en_o,
    output logic [DCACHE_TAG_SIZE-1:0]   fill_tag_o,
    output logic                         sb_push_o,
    output logic                         sb_pop_o,
    // MMU side
    output logic                         mmu_req_valid_o,
    output logic [ADDR_SIZE-1:0]         mmu_req_addr_o,
    input  logic                         mmu_req_ready_i,
    input  logic                         mmu_fill_valid_i,
    // Memory stage
    output logic                         mem_valid_o,
    output mem_cmd_e                     mem_cmd_o,
    output logic [ADDR_SIZE-1:0]         mem_addr_o,
    output logic [WORD_SIZE-1:0]         mem_data_o,
    output memop_type_e                  mem_type_o,
    output logic [DCACHE_INDEX_SIZE-1:0] mem_index_o,
    output logic [REG_SIZE-1:0]          mem_rf_waddr_o
);

    tl_state_e state_q;
    tl_state_e state_d;

    logic                       is_load;
    logic                       is_store;
    logic                       load_ok;
    logic                       drain_busy;
    logic [DCACHE_TAG_SIZE-1:0] miss_tag_q;

    assign is_load    = ex_valid_i & ex_rd_i;
    assign is_store   = ex_valid_i & ex_wr_i;
    assign load_ok    = ~conflict_i & (fwd_hit_i | tag_hit_i);
    assign drain_busy = (is_load & conflict_i) | (is_store & sb_full_i); // Must empty entries

    assign ex_ready_o = (state_q == TL_IDLE) & ex_valid_i & ~drain_busy & ~(is_load & ~load_ok);
    assign sb_push_o  = ex_ready_o & ex_wr_i;

    // Drain on idle cycles, or while an operation is blocked by the buffer
    assign sb_pop_o = sb_nonempty_i & (((state_q == TL_IDLE) & ~ex_valid_i) |
                                       ((state_q == TL_DRAIN) & drain_busy));

    // A drained store looks up its own line
    assign lookup_tag_o = sb_pop_o ? drain_addr_i[ADDR_SIZE-1:DCACHE_BYTE_SIZE]
                                   : ex_addr_i[ADDR_SIZE-1:DCACHE_BYTE_SIZE];

    assign fill_en_o      = (state_q == TL_MISS_WAIT) & mmu_fill_valid_i;
    assign fill_tag_o     = miss_tag_q;
    assign mmu_req_addr_o = {miss_tag_q, {DCACHE_BYTE_SIZE{1'b0}}}; // Line aligned

    always_comb begin
        state_d = state_q;
        case (state_q)
            TL_IDLE: begin
                if (drain_busy) state_d = TL_DRAIN;
                else if (is_load & ~load_ok) state_d = TL_MISS_WAIT;
            end
            TL_MISS_WAIT: begin
                if (mmu_fill_valid_i) state_d = TL_IDLE; // Load retries and hits
            end
            TL_DRAIN: begin
                if (!drain_busy) state_d = TL_IDLE;
            end
            default: state_d = TL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q         <= TL_IDLE;
            mmu_req_valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == TL_IDLE) && (state_d == TL_MISS_WAIT)) begin
                mmu_req_valid_o <= 1'b1;
            end else if (mmu_req_ready_i) begin
                mmu_req_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == TL_IDLE) && (state_d == TL_MISS_WAIT)) begin
            miss_tag_q <= ex_addr_i[ADDR_SIZE-1:DCACHE_BYTE_SIZE];
        end
    end

    // Memory stage command
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_valid_o <= 1'b0;
            mem_cmd_o   <= MEM_NONE;
        end else if (sb_pop_o) begin
            mem_valid_o <= 1'b1;
            mem_cmd_o   <= MEM_FLUSH;
        end else if (ex_ready_o & ex_rd_i) begin
            mem_valid_o <= 1'b1;
            mem_cmd_o   <= fwd_hit_i ? MEM_FWD : MEM_LOAD;
        end else begin
            mem_valid_o <= 1'b0;
            mem_cmd_o   <= MEM_NONE;
        end
    end

    always_ff @(posedge clk_i) begin
        mem_index_o <= tag_index_i; // Meaningful only when the line is cached
        if (sb_pop_o) begin
            mem_addr_o <= drain_addr_i;
            mem_data_o <= drain_data_i;
            mem_type_o <= drain_type_i;
        end else begin
            mem_addr_o     <= ex_addr_i;
            mem_data_o     <= fwd_data_i;
            mem_type_o     <= ex_type_i;
            mem_rf_waddr_o <= ex_rf_waddr_i;
        end
    end

endmodule

/* store_buffer.sv */
`timescale 1ns/10ps

module store_buffer import tl_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 push_i,
    input  logic                 pop_i,
    input  logic [ADDR_SIZE-1:0] addr_i,
    input  logic [WORD_SIZE-1:0] data_i,
    input  memop_type_e          type_i,
    output logic                 full_o,
    output logic                 nonempty_o,
    output logic                 fwd_hit_o,
    output logic [WORD_SIZE-1:0] fwd_data_o,
    output logic                 conflict_o,
    output logic [ADDR_SIZE-1:0] drain_addr_o,
    output logic [WORD_SIZE-1:0] drain_data_o,
    output memop_type_e          drain_type_o
);

    // Entry storage, data kept in its byte lanes
    logic [ADDR_SIZE-1:0] ent_addr [SB_DEPTH];
    logic [WORD_SIZE-1:0] ent_data [SB_DEPTH];
    logic [3:0]           ent_mask [SB_DEPTH];
    memop_type_e          ent_type [SB_DEPTH];

    logic [SB_PTR_SIZE-1:0] wr_ptr_q;
    logic [SB_PTR_SIZE-1:0] rd_ptr_q;
    logic [SB_PTR_SIZE:0]   count_q;

    logic [3:0]             req_mask;
    logic [WORD_SIZE-1:0]   lane_mask;
    logic                   fwd_found;
    logic [SB_PTR_SIZE-1:0] fwd_slot;

    function automatic logic [3:0] byte_mask(memop_type_e t, logic [1:0] off);
        case (t)
            BYTE:    return 4'b0001 << off;
            HALF:    return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    // Shift lane data down and zero-extend to the access size
    function automatic logic [WORD_SIZE-1:0] extract(logic [WORD_SIZE-1:0] lane,
                                                     logic [1:0] off, memop_type_e t);
        logic [WORD_SIZE-1:0] sh;
        sh = lane >> {off, 3'b000};
        case (t)
            BYTE:    return {{(WORD_SIZE-8){1'b0}}, sh[7:0]};
            HALF:    return {{(WORD_SIZE-16){1'b0}}, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    assign req_mask  = byte_mask(type_i, addr_i[1:0]);
    assign lane_mask = {{8{req_mask[3]}}, {8{req_mask[2]}}, {8{req_mask[1]}}, {8{req_mask[0]}}};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (SB_PTR_SIZE+1)'(push_i) - (SB_PTR_SIZE+1)'(pop_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            ent_addr[wr_ptr_q] <= addr_i;
            ent_data[wr_ptr_q] <= (data_i << {addr_i[1:0], 3'b000}) & lane_mask;
            ent_mask[wr_ptr_q] <= req_mask;
            ent_type[wr_ptr_q] <= type_i;
        end
    end

    assign full_o     = (count_q == (SB_PTR_SIZE+1)'(SB_DEPTH));
    assign nonempty_o = (count_q != '0);

    // Walk oldest to newest, the last overlapping entry wins
    always_comb begin
        logic [SB_PTR_SIZE-1:0] slot;
        fwd_found = 1'b0;
        fwd_slot  = rd_ptr_q;
        for (int i = 0; i < SB_DEPTH; i++) begin
            slot = rd_ptr_q + SB_PTR_SIZE'(i);
            if ((i < int'(count_q)) &&
                (ent_addr[slot][ADDR_SIZE-1:2] == addr_i[ADDR_SIZE-1:2]) &&
                |(ent_mask[slot] & req_mask)) begin
                fwd_found = 1'b1;
                fwd_slot  = slot;
            end
        end
    end

    // Newest overlap must cover every requested byte, else drain first
    assign fwd_hit_o  = fwd_found & ((req_mask & ~ent_mask[fwd_slot]) == 4'b0000);
    assign conflict_o = fwd_found & ((req_mask & ~ent_mask[fwd_slot]) != 4'b0000);
    assign fwd_data_o = extract(ent_data[fwd_slot], addr_i[1:0], type_i);

    // Oldest entry goes out first
    assign drain_addr_o = ent_addr[rd_ptr_q];
    assign drain_type_o = ent_type[rd_ptr_q];
    assign drain_data_o = extract(ent_data[rd_ptr_q], ent_addr[rd_ptr_q][1:0], ent_type[rd_ptr_q]);

endmodule

/* dcache_tag_array.sv */
`timescale 1ns/10ps

module dcache_tag_array import tl_pkg::*; (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic [DCACHE_TAG_SIZE-1:0]   lookup_tag_i,
    input  logic                         fill_en_i,
    input  logic [DCACHE_TAG_SIZE-1:0]   fill_tag_i,
    input  logic [DCACHE_INDEX_SIZE-1:0] fill_index_i,
    output logic                         hit_o,
    output logic [DCACHE_INDEX_SIZE-1:0] index_o
);

    logic [DCACHE_LINES-1:0]    valid_q;
    logic [DCACHE_TAG_SIZE-1:0] tag_q [DCACHE_LINES];
    logic [DCACHE_LINES-1:0]    match;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (fill_en_i) begin
            valid_q[fill_index_i] <= 1'b1;
        end
    end

    // Victim slot picked by the MMU
    always_ff @(posedge clk_i) begin
        if (fill_en_i) begin
            tag_q[fill_index_i] <= fill_tag_i;
        end
    end

    // Parallel compare against every line
    always_comb begin
        for (int i = 0; i < DCACHE_LINES; i++) begin
            match[i] = valid_q[i] & (tag_q[i] == lookup_tag_i);
        end
    end

    assign hit_o = |match;

    // At most one line matches, so a plain encoder is enough
    always_comb begin
        index_o = '0;
        for (int i = 0; i < DCACHE_LINES; i++) begin
            if (match[i]) begin
                index_o = DCACHE_INDEX_SIZE'(i);
            end
        end
    end

endmodule

/* tl_pkg.sv */
package tl_pkg;

    // Datapath widths
    localparam int WORD_SIZE = 32;
    localparam int ADDR_SIZE = 32;
    localparam int REG_SIZE  = 5;   // Register file address

    // Data cache geometry, 16-byte lines
    localparam int DCACHE_BYTE_SIZE  = 4;
    localparam int DCACHE_LINES      = 8;
    localparam int DCACHE_INDEX_SIZE = 3;
    localparam int DCACHE_TAG_SIZE   = ADDR_SIZE - DCACHE_BYTE_SIZE;

    // Store buffer
    localparam int SB_DEPTH    = 4;
    localparam int SB_PTR_SIZE = 2;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_type_e;

    // Command handed to the memory stage
    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_LOAD  = 2'b01,  // Read cache line at index
        MEM_FWD   = 2'b10,  // Data already served by the store buffer
        MEM_FLUSH = 2'b11   // Write back a drained store
    } mem_cmd_e;

    typedef enum logic [1:0] {
        TL_IDLE      = 2'b00,
        TL_MISS_WAIT = 2'b01,
        TL_DRAIN     = 2'b10
    } tl_state_e;

endpackage
